//--- all.f
src/hist_cfg_pkg.sv
src/hist_cmd_pkg.sv
src/cmd_decoder.sv
src/tap_buffer.sv
src/result_merger.sv
src/tap_history_bank.sv
bench/tb_tap_history_bank.sv

//--- run.sh
#!/bin/sh
# Build and run the tap history bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_tap_history_bank \
    -Mdir obj_dir \
    -o sim_tap_history_bank
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tap_history_bank 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- bench/tb_tap_history_bank.sv
// Tap history bank testbench: directed tests against a ring buffer model with timed result checks
`timescale 1ns/100ps

module tb_tap_history_bank
    import hist_cfg_pkg::*;
    import hist_cmd_pkg::*;
;

    // Edges from the sampling edge of a read to its result pulse
    localparam int RESULT_LATENCY = 4;
    localparam int RESET_CYCLES   = 5;

    // Commands issued by each test
    localparam int OFFSET_CMDS = 16;
    localparam int POP_CMDS    = 18;
    localparam int LANE_CMDS   = 36;
    localparam int WRAP_CMDS   = 19;
    localparam int RANDOM_CMDS = 200;
    localparam int CYCLE_LIMIT = OFFSET_CMDS + POP_CMDS + LANE_CMDS + WRAP_CMDS
                                 + RANDOM_CMDS + 64;

    localparam logic [31:0] LFSR_SEED = 32'd92760;

    // One outstanding read as the model sees it
    typedef struct packed {
        logic [LANE_W-1:0]   lane;
        logic [SAMPLE_W-1:0] sample;
        logic [31:0]         due;
    } expected_t;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    cmd_word_t cmd;
    logic      result_valid;
    result_t   result;

    // Reference model of every lane
    logic [SAMPLE_W-1:0] model_mem [NUM_LANES][DEPTH];
    logic [PTR_W-1:0]    model_wr [NUM_LANES];
    logic [PTR_W-1:0]    model_rd [NUM_LANES];
    expected_t           exp_q [$];

    logic [31:0] cycle_count = '0;
    logic [31:0] lfsr_state;

    tap_history_bank UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run;
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic report_mismatch(input string what);
        $display("** Error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Cycle counter and run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            report_problem($sformatf("Timeout: the run went past %0d cycles", CYCLE_LIMIT));
        end
    end

    // Results are looked at mid-cycle, away from the driving edge
    always @(negedge clk) begin : check_results
        expected_t head;
        if (result_valid) begin
            assert (exp_q.size() != 0)
            else report_problem("A result pulse arrived with no read outstanding");
            head = exp_q.pop_front();
            assert (cycle_count == head.due)
            else report_mismatch($sformatf("result at cycle %0d, expected at cycle %0d",
                                           cycle_count, head.due));
            assert (result.lane == head.lane)
            else report_mismatch($sformatf("result lane %0d, expected lane %0d",
                                           result.lane, head.lane));
            assert (result.sample == head.sample)
            else report_mismatch($sformatf("lane %0d sample 0x%04h, expected 0x%04h",
                                           head.lane, result.sample, head.sample));
        end else if (exp_q.size() != 0) begin
            assert (exp_q[0].due > cycle_count)
            else report_problem(
                $sformatf("No result came for the read on lane %0d due at cycle %0d",
                          exp_q[0].lane, exp_q[0].due));
        end
    end

    task automatic issue_write(input logic [LANE_W-1:0] lane, input logic [SAMPLE_W-1:0] sample);
        cmd_word_t w;
        w = '0;
        w.op             = OP_WRITE;
        w.lane           = lane;
        w.payload.sample = sample;
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd       = w;
        model_mem[lane][model_wr[lane]] = sample;
        model_wr[lane] = model_wr[lane] + PTR_W'(1);
    endtask

    task automatic issue_read(input logic [LANE_W-1:0] lane, input logic [OFFSET_W-1:0] offset,
                              input logic pop);
        cmd_word_t        w;
        expected_t        e;
        logic [PTR_W-1:0] addr;
        w = '0;
        w.op                 = OP_READ;
        w.lane               = lane;
        w.payload.req.pop    = pop;
        w.payload.req.offset = offset;
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd       = w;
        // Slot address wraps modulo DEPTH, pop is applied after the read
        addr     = model_rd[lane] + PTR_W'(offset);
        e.lane   = lane;
        e.sample = model_mem[lane][addr];
        // Sampled on the next edge, result pulse RESULT_LATENCY edges later
        e.due    = cycle_count + 1 + RESULT_LATENCY;
        exp_q.push_back(e);
        if (pop) begin
            model_rd[lane] = model_rd[lane] + PTR_W'(1);
        end
    endtask

    task automatic go_idle;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    task automatic wait_drain;
        go_idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic reset_check;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            assert (result_valid == 1'b0 && result == '0)
            else report_mismatch("result not cleared during reset");
        end
        rst_n = 1'b1;
        // Quiet bus after reset
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            assert (result_valid == 1'b0 && result == '0)
            else report_mismatch("result changed with no commands after reset");
        end
    endtask

    task automatic write_then_read_offsets;
        for (int i = 0; i < DEPTH; i++) begin
            issue_write(2'd0, SAMPLE_W'(16'h1100 + i));
        end
        for (int i = 0; i < DEPTH; i++) begin
            issue_read(2'd0, OFFSET_W'(i), 1'b0);
        end
        wait_drain();
    endtask

    // Nine pops take the read pointer past slot 7 and back to 0
    task automatic pop_advances;
        for (int i = 0; i < 9; i++) begin
            issue_read(2'd0, 3'd0, 1'b1);
            issue_read(2'd0, 3'd0, 1'b0);
        end
        wait_drain();
    endtask

    task automatic lane_independence;
        for (int k = 0; k < DEPTH; k++) begin
            issue_write(2'd1, SAMPLE_W'(16'h2100 + k));
            issue_write(2'd2, SAMPLE_W'(16'h2200 + k));
            issue_write(2'd3, SAMPLE_W'(16'h2300 + k));
            issue_read(2'd0, OFFSET_W'(k), 1'b0);
        end
        for (int l = 1; l < NUM_LANES; l++) begin
            issue_read(LANE_W'(l), 3'd1, 1'b1);
        end
        issue_read(2'd0, 3'd0, 1'b0);
        wait_drain();
    endtask

    task automatic wrap_overwrite;
        for (int i = 0; i < 11; i++) begin
            issue_write(2'd2, SAMPLE_W'(16'h3300 + i));
        end
        for (int i = 0; i < DEPTH; i++) begin
            issue_read(2'd2, OFFSET_W'(i), 1'b0);
        end
        wait_drain();
    endtask

    // Every slot of every lane holds a known sample by now
    task automatic random_back_to_back;
        logic                op;
        logic [LANE_W-1:0]   lane;
        logic [OFFSET_W-1:0] offset;
        logic                pop;
        logic [SAMPLE_W-1:0] sample;
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            op   = take_bits(1) != 0;
            lane = LANE_W'(take_bits(LANE_W));
            if (op) begin
                pop    = take_bits(1) != 0;
                offset = OFFSET_W'(take_bits(OFFSET_W));
                issue_read(lane, offset, pop);
            end else begin
                sample = SAMPLE_W'(take_bits(SAMPLE_W));
                issue_write(lane, sample);
            end
        end
        wait_drain();
    endtask

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        lfsr_state = LFSR_SEED;
        for (int l = 0; l < NUM_LANES; l++) begin
            model_wr[l] = '0;
            model_rd[l] = '0;
        end

        $display("Running reset_check");
        reset_check();
        $display("Running write_then_read_offsets");
        write_then_read_offsets();
        $display("Running pop_advances");
        pop_advances();
        $display("Running lane_independence");
        lane_independence();
        $display("Running wrap_overwrite");
        wrap_overwrite();
        $display("Running random_back_to_back");
        random_back_to_back();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- src/tap_history_bank.sv
// Tap history bank top level: decoder, a row of tap buffers and the result merger
`timescale 1ns/100ps

module tap_history_bank
    import hist_cfg_pkg::*;
    import hist_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  cmd_word_t cmd,
    output logic      result_valid,
    output result_t   result
);

    lane_req_t lane_req [NUM_LANES];
    lane_rsp_t lane_rsp [NUM_LANES];

    // One request per lane, at most one active
    cmd_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .lane_req  (lane_req)
    );

    // Identical lanes, indexed by the generate constant
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        tap_buffer u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (lane_req[g]),
            .rsp   (lane_rsp[g])
        );
    end

    // Tagged result, one pulse per read
    result_merger u_merger (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_rsp     (lane_rsp),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

//--- src/result_merger.sv
// Result merger: folds the lane responses into one registered tagged result
`timescale 1ns/100ps

module result_merger
    import hist_cfg_pkg::*;
    import hist_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  lane_rsp_t lane_rsp [NUM_LANES],
    output logic      result_valid,
    output result_t   result
);

    logic                hit;
    logic [LANE_W-1:0]   hit_lane;
    logic [SAMPLE_W-1:0] hit_sample;

    // At most one lane responds per cycle, so a plain scan is enough
    always_comb begin
        hit        = 1'b0;
        hit_lane   = '0;
        hit_sample = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_rsp[i].valid) begin
                hit        = 1'b1;
                hit_lane   = LANE_W'(i);
                hit_sample = lane_rsp[i].sample;
            end
        end
    end

    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= hit;
            // Result holds its last value between pulses
            if (hit) begin
                result.lane   <= hit_lane;
                result.sample <= hit_sample;
            end
        end
    end

endmodule

//--- src/tap_buffer.sv
// Tap buffer: one lane's ring memory read back at read pointer plus offset
`timescale 1ns/100ps

module tap_buffer
    import hist_cfg_pkg::*;
    import hist_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  lane_req_t req,
    output lane_rsp_t rsp
);

    // Ring storage
    logic [SAMPLE_W-1:0] mem [DEPTH];

    // Pointers wrap freely, no full or empty tracking
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;

    // Address stage
    logic [PTR_W:0]      addr_sum;
    logic [PTR_W-1:0]    rd_addr;
    logic                rd_valid;

    // Data stage
    logic                rsp_valid_q;
    logic [SAMPLE_W-1:0] rsp_sample_q;

    // Shifted address from the pointer before any pop on this edge
    assign addr_sum = (PTR_W+1)'(rd_ptr) + (PTR_W+1)'(req.offset);

    // Sample write at the write pointer
    always_ff @(posedge clk) begin
        if (req.write) begin
            mem[wr_ptr] <= req.sample;
        end
    end

    // Write pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (req.write) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
        end
    end

    // Read pointer, a pop moves it after the read has used the old value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (req.read && req.pop) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
        end
    end

    // First read stage latches the address and the valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.read;
        end
    end

    always_ff @(posedge clk) begin
        if (req.read) begin
            rd_addr <= PTR_W'(addr_sum % DEPTH);
        end
    end

    // Second read stage registers the memory word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rsp_sample_q <= mem[rd_addr];
        end
    end

    assign rsp.valid  = rsp_valid_q;
    assign rsp.sample = rsp_sample_q;

endmodule

//--- src/cmd_decoder.sv
// Command decoder: registers each command and steers it as a request to one lane
`timescale 1ns/100ps

module cmd_decoder
    import hist_cfg_pkg::*;
    import hist_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  cmd_word_t cmd,
    output lane_req_t lane_req [NUM_LANES]
);

    logic      cmd_valid_q;
    cmd_word_t cmd_q;
    lane_req_t req_next [NUM_LANES];

    // Input stage, strobe only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid;
        end
    end

    // Command word is only looked at while the strobe is set
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            cmd_q <= cmd;
        end
    end

    // Decode the op and read the union in the matching view
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            req_next[i] = '0;
            if (cmd_valid_q && (cmd_q.lane == LANE_W'(i))) begin
                if (cmd_q.op == OP_WRITE) begin
                    req_next[i].write  = 1'b1;
                    req_next[i].sample = cmd_q.payload.sample;
                end else begin
                    req_next[i].read   = 1'b1;
                    req_next[i].pop    = cmd_q.payload.req.pop;
                    req_next[i].offset = cmd_q.payload.req.offset;
                end
            end
        end
    end

    // Request stage, all unaddressed lanes see an idle request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_req[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_req[i] <= req_next[i];
            end
        end
    end

endmodule

//--- src/hist_cmd_pkg.sv
// Tap history bank formats: command word, payload views, lane request/response and result
package hist_cmd_pkg;

    import hist_cfg_pkg::*;

    // Command operation
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } cmd_op_e;

    // Payload seen as a read request
    typedef struct packed {
        logic                             pop;
        logic [OFFSET_W-1:0]              offset;
        logic [SAMPLE_W-OFFSET_W-2:0]     reserved;
    } read_req_t;

    // One payload word, decoded by the op
    typedef union packed {
        logic [SAMPLE_W-1:0] sample;
        read_req_t           req;
    } cmd_payload_u;

    // Command word from the host side
    typedef struct packed {
        cmd_op_e             op;
        logic [LANE_W-1:0]   lane;
        cmd_payload_u        payload;
    } cmd_word_t;

    // Request steered to a single lane
    typedef struct packed {
        logic                write;
        logic                read;
        logic                pop;
        logic [OFFSET_W-1:0] offset;
        logic [SAMPLE_W-1:0] sample;
    } lane_req_t;

    // Read data leaving a lane
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] sample;
    } lane_rsp_t;

    // Tagged result of a read command
    typedef struct packed {
        logic [LANE_W-1:0]   lane;
        logic [SAMPLE_W-1:0] sample;
    } result_t;

endpackage

//--- src/hist_cfg_pkg.sv
// Tap history bank sizes: lane count, ring depth, sample width and pointer widths
package hist_cfg_pkg;

    // Number of independent channels in the bank
    localparam int NUM_LANES = 4;

    // Slots held by each lane's ring memory
    localparam int DEPTH = 8;

    // Width of one stored sample
    localparam int SAMPLE_W = 16;

    // Slot pointer width, follows the depth
    localparam int PTR_W = $clog2(DEPTH);

    // Lane select width in the command word
    localparam int LANE_W = $clog2(NUM_LANES);

    // Read offset width, covers every slot of a lane
    localparam int OFFSET_W = 3;

endpackage
